// ==== logic/frame_decode.sv ====
module frame_decode
    import uart_slave_pkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic busy,
    output cmd_t cmd
);

    logic [FRAME_LEN-1:0]       frame_q;
    logic [FRAME_CNT_WIDTH-1:0] bit_cnt;
    logic                       frame_done;
    logic                       blocked;
    logic                       start_ok;
    logic                       id_ok;

    // control sampled every cycle so the oldest bit ends up on top
    always_ff @(posedge clk) begin
        frame_q <= {frame_q[FRAME_LEN-2:0], control};
    end

    // bit_cnt is zero while waiting for a frame to begin
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
            blocked    <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (bit_cnt == '0) begin
                if (control) begin
                    bit_cnt <= FRAME_CNT_WIDTH'(1);
                    // a command issued this cycle has not raised busy yet
                    blocked <= busy | cmd.valid;
                end
            end else if (bit_cnt == FRAME_CNT_WIDTH'(FRAME_LEN - 1)) begin
                bit_cnt    <= '0;
                frame_done <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // field checks on the complete frame
    assign start_ok = frame_q[FRAME_LEN-1 -: 3] == START_CODE;
    assign id_ok = frame_q[ID_WIDTH:1] == SLAVE_ID;

    assign cmd.valid = frame_done && !blocked && start_ok && id_ok;
    assign cmd.rw = frame_q[0];

endmodule

// ==== logic/link_write.sv ====
module link_write
    import uart_slave_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  cmd_t                    cmd,
    input  logic                    wd,
    input  logic                    valid,
    output link_tx_t                send_tx,
    input  logic                    send_tx_ready,
    input  link_rx_t                send_rx,
    output logic [STATUS_WIDTH-1:0] status,
    output logic                    busy
);

    typedef enum logic [1:0] {
        LW_IDLE,
        LW_SHIFT,
        LW_LAUNCH,
        LW_WAIT
    } lw_state_t;

    lw_state_t                  state;
    logic [DATA_WIDTH-1:0]      data_q;
    logic [DATA_WIDTH-1:0]      sent_q;
    logic [DATA_CNT_WIDTH-1:0]  bit_cnt;
    logic [ACK_CNT_WIDTH-1:0]   timer;
    logic [RETRY_CNT_WIDTH-1:0] retries;
    logic                       launch;
    logic                       timed_out;

    // strobe only goes out while the transmitter is ready
    assign launch = (state == LW_LAUNCH) && send_tx_ready;
    assign timed_out = timer == ACK_CNT_WIDTH'(ACK_TIMEOUT - 1);

    assign send_tx.start = launch;
    // new word appears with its strobe and is held until the next one
    assign send_tx.word = launch ? data_q : sent_q;
    assign busy = state != LW_IDLE;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= LW_IDLE;
            bit_cnt <= '0;
            timer   <= '0;
            retries <= '0;
            sent_q  <= '0;
            status  <= NAK_STATUS;
        end else begin
            case (state)
                LW_IDLE: begin
                    if (cmd.valid && cmd.rw) begin
                        bit_cnt <= '0;
                        retries <= '0;
                        state   <= LW_SHIFT;
                    end
                end
                // master may pause by dropping valid
                LW_SHIFT: begin
                    if (valid) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == DATA_CNT_WIDTH'(DATA_WIDTH - 1)) begin
                            state <= LW_LAUNCH;
                        end
                    end
                end
                LW_LAUNCH: begin
                    if (send_tx_ready) begin
                        sent_q <= data_q;
                        timer  <= '0;
                        state  <= LW_WAIT;
                    end
                end
                LW_WAIT: begin
                    if (send_rx.done) begin
                        status <= (send_rx.word == ACK_CODE) ? ACK_STATUS : NAK_STATUS;
                        state  <= LW_IDLE;
                    end else if (timed_out) begin
                        if (retries == RETRY_CNT_WIDTH'(RETRANSMIT_TIMES)) begin
                            // out of retries
                            status <= NAK_STATUS;
                            state  <= LW_IDLE;
                        end else begin
                            retries <= retries + 1'b1;
                            state   <= LW_LAUNCH;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: state <= LW_IDLE;
            endcase
        end
    end

    // write word shifted in msb first
    always_ff @(posedge clk) begin
        if (state == LW_SHIFT && valid) begin
            data_q <= {data_q[DATA_WIDTH-2:0], wd};
        end
    end

endmodule

// ==== logic/read_return.sv ====
module read_return
    import uart_slave_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  cmd_t                    cmd,
    input  logic [STATUS_WIDTH-1:0] status,
    input  link_rx_t                get_rx,
    output link_tx_t                get_tx,
    input  logic                    get_tx_ready,
    output logic                    rd,
    output logic                    ready,
    output logic                    busy
);

    typedef enum logic [1:0] {
        RR_IDLE,
        RR_WAIT_RX,
        RR_SEND_ACK,
        RR_OUT
    } rr_state_t;

    rr_state_t                state;
    logic [OUT_LEN-1:0]       out_q;
    logic [OUT_CNT_WIDTH-1:0] out_cnt;
    logic [DATA_WIDTH-1:0]    ack_q;
    logic                     ack_send;

    assign ack_send = (state == RR_SEND_ACK) && get_tx_ready;

    assign get_tx.start = ack_send;
    assign get_tx.word = ack_send ? ACK_CODE : ack_q;

    // low only while the read is pending
    assign ready = !(state == RR_WAIT_RX || state == RR_SEND_ACK);
    assign rd = (state == RR_OUT) && out_q[OUT_LEN-1];
    assign busy = state != RR_IDLE;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= RR_IDLE;
            out_cnt <= '0;
            ack_q   <= '0;
        end else begin
            case (state)
                RR_IDLE: begin
                    if (cmd.valid && !cmd.rw) begin
                        state <= RR_WAIT_RX;
                    end
                end
                RR_WAIT_RX: begin
                    if (get_rx.done) begin
                        state <= RR_SEND_ACK;
                    end
                end
                RR_SEND_ACK: begin
                    if (get_tx_ready) begin
                        ack_q   <= ACK_CODE;
                        out_cnt <= '0;
                        state   <= RR_OUT;
                    end
                end
                // twelve back to back bits to the master
                RR_OUT: begin
                    out_cnt <= out_cnt + 1'b1;
                    if (out_cnt == OUT_CNT_WIDTH'(OUT_LEN - 1)) begin
                        state <= RR_IDLE;
                    end
                end
                default: state <= RR_IDLE;
            endcase
        end
    end

    // status nibble in front of the received word
    always_ff @(posedge clk) begin
        if (state == RR_WAIT_RX && get_rx.done) begin
            out_q <= {status, get_rx.word};
        end else if (state == RR_OUT) begin
            out_q <= {out_q[OUT_LEN-2:0], 1'b0};
        end
    end

endmodule

// ==== logic/uart_slave.sv ====
module uart_slave
    import uart_slave_pkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    // master side
    input  logic     control,
    input  logic     wd,
    input  logic     valid,
    output logic     rd,
    output logic     ready,
    // next board
    output link_tx_t send_tx,
    input  logic     send_tx_ready,
    input  link_rx_t send_rx,
    // previous board
    output link_tx_t get_tx,
    input  logic     get_tx_ready,
    input  link_rx_t get_rx
);

    cmd_t                    cmd;
    logic [STATUS_WIDTH-1:0] status;
    logic                    write_busy;
    logic                    read_busy;
    logic                    busy;

    // one transfer at a time
    assign busy = write_busy | read_busy;

    frame_decode i_frame_decode (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .busy    (busy),
        .cmd     (cmd)
    );

    link_write i_link_write (
        .clk           (clk),
        .rstN          (rstN),
        .cmd           (cmd),
        .wd            (wd),
        .valid         (valid),
        .send_tx       (send_tx),
        .send_tx_ready (send_tx_ready),
        .send_rx       (send_rx),
        .status        (status),
        .busy          (write_busy)
    );

    read_return i_read_return (
        .clk          (clk),
        .rstN         (rstN),
        .cmd          (cmd),
        .status       (status),
        .get_rx       (get_rx),
        .get_tx       (get_tx),
        .get_tx_ready (get_tx_ready),
        .rd           (rd),
        .ready        (ready),
        .busy         (read_busy)
    );

endmodule

// ==== logic/uart_slave_pkg.sv ====
package uart_slave_pkg;

    // word sizes
    localparam int DATA_WIDTH = 8;
    localparam int ID_WIDTH = 2;
    localparam int STATUS_WIDTH = 4;

    // addressing
    localparam logic [ID_WIDTH-1:0] SLAVE_ID = 2'd1;
    localparam int FRAME_LEN = 3 + ID_WIDTH + 1;
    localparam logic [2:0] START_CODE = 3'b111;

    // link reply words
    localparam logic [DATA_WIDTH-1:0] ACK_CODE = 8'hCC;
    localparam logic [DATA_WIDTH-1:0] NAK_CODE = 8'hAA;

    // status reported back to the master is the top nibble of the reply
    localparam logic [STATUS_WIDTH-1:0] ACK_STATUS = ACK_CODE[DATA_WIDTH-1 -: STATUS_WIDTH];
    localparam logic [STATUS_WIDTH-1:0] NAK_STATUS = NAK_CODE[DATA_WIDTH-1 -: STATUS_WIDTH];

    // reply wait and retry limits
    localparam int ACK_TIMEOUT = 40;
    localparam int RETRANSMIT_TIMES = 3;

    // counter widths
    localparam int FRAME_CNT_WIDTH = $clog2(FRAME_LEN);
    localparam int DATA_CNT_WIDTH = $clog2(DATA_WIDTH);
    localparam int ACK_CNT_WIDTH = $clog2(ACK_TIMEOUT);
    localparam int RETRY_CNT_WIDTH = $clog2(RETRANSMIT_TIMES + 1);

    // read reply is status followed by the word
    localparam int OUT_LEN = STATUS_WIDTH + DATA_WIDTH;
    localparam int OUT_CNT_WIDTH = $clog2(OUT_LEN);

    typedef struct packed {
        logic                  start;
        logic [DATA_WIDTH-1:0] word;
    } link_tx_t;

    typedef struct packed {
        logic                  done;
        logic [DATA_WIDTH-1:0] word;
    } link_rx_t;

    // rw set means write
    typedef struct packed {
        logic valid;
        logic rw;
    } cmd_t;

endpackage

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_uart_slave -o sim_uart_slave > build.log 2>&1 &&
./obj_dir/sim_uart_slave > sim.log 2>&1
grep -q "Simulation finished: PASS" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// ==== sim/tb_uart_slave.sv ====
module tb_uart_slave
    import uart_slave_pkg::*;
();

    localparam int N_TRANS = 60;
    localparam int LIMIT_CYCLES = N_TRANS * (RETRANSMIT_TIMES + 1) * ACK_TIMEOUT + 2000;

    logic clk, rstN, control, wd, valid, rd, ready;
    logic send_tx_ready, get_tx_ready;
    link_tx_t send_tx, get_tx;
    link_rx_t send_rx, get_rx;

    int errors;
    int checks;
    int send_starts;
    int reply_strobe;
    logic replied;
    logic word_changed;
    logic [DATA_WIDTH-1:0] first_word;
    logic [DATA_WIDTH-1:0] reply_code;
    logic [DATA_WIDTH-1:0] get_word;
    logic [STATUS_WIDTH-1:0] exp_status;

    uart_slave i_uart_slave (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(LIMIT_CYCLES * 8);
        $display("watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    always @(posedge clk) begin
        send_tx_ready <= ($urandom % 4) != 0;
        get_tx_ready <= ($urandom % 4) != 0;
    end

    // next board answers each strobe with ack, nak or silence
    initial begin
        int mode;
        forever begin
            @(posedge clk);
            if (rstN && send_tx.start) begin
                if (send_starts == 0) first_word = send_tx.word;
                else if (send_tx.word != first_word) word_changed = 1'b1;
                send_starts++;
                mode = $urandom % 4;
                if (mode < 2) begin
                    reply_code = (mode == 0) ? 8'hCC : 8'hAA;
                    if (!replied) reply_strobe = send_starts;
                    replied = 1'b1;
                    repeat (1 + $urandom % 30) @(posedge clk);
                    send_rx.word <= reply_code;
                    send_rx.done <= 1'b1;
                    @(posedge clk);
                    send_rx.done <= 1'b0;
                end
            end
        end
    end

    // previous board delivers a word once a read is pending
    initial begin
        forever begin
            @(posedge clk);
            if (rstN && !ready) begin
                repeat (10 + $urandom % 20) @(posedge clk);
                get_word = DATA_WIDTH'($urandom);
                get_rx.word <= get_word;
                get_rx.done <= 1'b1;
                @(posedge clk);
                get_rx.done <= 1'b0;
                while (!ready) @(posedge clk);
            end
        end
    end

    task automatic send_frame(input logic [FRAME_LEN-1:0] frame);
        for (int i = FRAME_LEN - 1; i >= 0; i--) begin
            @(posedge clk);
            control <= frame[i];
        end
        @(posedge clk);
        control <= 1'b0;
    endtask

    task automatic write_transfer(input logic [1:0] id, input logic [2:0] start);
        logic [DATA_WIDTH-1:0] data;
        int exp_starts;
        data = DATA_WIDTH'($urandom);
        send_starts = 0;
        replied = 1'b0;
        word_changed = 1'b0;
        send_frame({start, id, 1'b1});
        for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
            while ($urandom % 4 == 0) begin
                @(posedge clk);
                valid <= 1'b0;
            end
            @(posedge clk);
            wd <= data[i];
            valid <= 1'b1;
        end
        @(posedge clk);
        valid <= 1'b0;
        checks++;
        if (id == 2'd1 && start == 3'b111) begin
            while (i_uart_slave.busy) @(posedge clk);
            if (first_word != data) begin
                $display("Error write_data: expected %h, actual %h", data, first_word);
                errors++;
            end
            if (word_changed) begin
                $display("retransmitted word differs from the first one");
                errors++;
            end
            // retransmission stops at the first reply
            exp_starts = replied ? reply_strobe : 1 + RETRANSMIT_TIMES;
            if (send_starts != exp_starts) begin
                $display("Error retransmit_count: expected %0d, actual %0d",
                         exp_starts, send_starts);
                errors++;
            end
            exp_status = (replied && reply_code == 8'hCC) ? 4'hC : 4'hA;
        end else begin
            repeat (4) @(posedge clk);
            if (send_starts != 0 || !ready) begin
                $display("ignored write frame caused a strobe or dropped ready");
                errors++;
            end
        end
    endtask

    task automatic read_transfer(input logic [1:0] id, input logic [2:0] start,
                                 input logic inject);
        logic [OUT_LEN-1:0] bits;
        int gets;
        int guard;
        gets = 0;
        guard = 0;
        send_frame({start, id, 1'b0});
        checks++;
        if (id != 2'd1 || start != 3'b111) begin
            repeat (4) @(posedge clk);
            if (!ready || get_tx.start) begin
                $display("ignored read frame dropped ready or sent an ack");
                errors++;
            end
            return;
        end
        while (ready && guard < 10) begin
            @(posedge clk);
            guard++;
        end
        // a frame begun now must be ignored
        if (inject) send_frame({3'b111, 2'd1, 1'b1});
        @(posedge clk);
        while (!ready) begin
            if (get_tx.start) begin
                gets++;
                if (get_tx.word != 8'hCC) begin
                    $display("Error read_ack: expected %h, actual %h", 8'hCC, get_tx.word);
                    errors++;
                end
            end
            @(posedge clk);
        end
        if (gets != 1) begin
            $display("Error read_ack_count: expected %0d, actual %0d", 1, gets);
            errors++;
        end
        bits[OUT_LEN-1] = rd;
        for (int k = OUT_LEN - 2; k >= 0; k--) begin
            @(posedge clk);
            bits[k] = rd;
        end
        if (bits != {exp_status, get_word}) begin
            $display("Error read_return: expected %h, actual %h", {exp_status, get_word}, bits);
            errors++;
        end
        @(posedge clk);
        if (inject && i_uart_slave.busy) begin
            $display("write frame begun during a read was not ignored");
            errors++;
        end
    endtask

    initial begin
        int kind;
        void'($urandom(32'hf0f9_fb84));
        errors = 0;
        checks = 0;
        send_starts = 0;
        exp_status = 4'hA;
        rstN = 1'b0;
        control = 1'b0;
        wd = 1'b0;
        valid = 1'b0;
        send_tx_ready = 1'b0;
        get_tx_ready = 1'b0;
        send_rx = '0;
        get_rx = '0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        if (!ready || send_tx.start || get_tx.start) begin
            $display("reset state wrong: ready low or a strobe active");
            errors++;
        end
        read_transfer(2'd1, 3'b111, 1'b0);
        for (int n = 0; n < N_TRANS; n++) begin
            kind = $urandom % 6;
            case (kind)
                0, 1: write_transfer(2'd1, 3'b111);
                2: read_transfer(2'd1, 3'b111, 1'b0);
                3: begin
                    if ($urandom % 2 == 0) write_transfer(2'd1 ^ 2'($urandom % 3 + 1), 3'b111);
                    else read_transfer(2'd1 ^ 2'($urandom % 3 + 1), 3'b111, 1'b0);
                end
                4: write_transfer(2'd1, 3'b111 ^ 3'(1 << ($urandom % 2)));
                default: read_transfer(2'd1, 3'b111, 1'b1);
            endcase
        end
        read_transfer(2'd1, 3'b111, 1'b0);
        $display("transactions checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/uart_slave_assert.sv ====
module uart_slave_assert
    import uart_slave_pkg::*;
(
    input logic     clk,
    input logic     rstN,
    input link_tx_t send_tx,
    input logic     send_tx_ready,
    input link_tx_t get_tx,
    input logic     get_tx_ready,
    input logic     ready,
    input cmd_t     cmd
);

    // strobes only while the link can take them
    a_send_ready: assert property (@(posedge clk) disable iff (!rstN)
        send_tx.start |-> send_tx_ready) else $error("send strobe without ready");
    a_get_ready: assert property (@(posedge clk) disable iff (!rstN)
        get_tx.start |-> get_tx_ready) else $error("get strobe without ready");

    a_send_pulse: assert property (@(posedge clk) disable iff (!rstN)
        send_tx.start |=> !send_tx.start) else $error("send strobe longer than one cycle");
    a_get_pulse: assert property (@(posedge clk) disable iff (!rstN)
        get_tx.start |=> !get_tx.start) else $error("get strobe longer than one cycle");

    // word may only change together with a strobe
    a_send_word: assert property (@(posedge clk) disable iff (!rstN)
        !send_tx.start |-> send_tx.word == $past(send_tx.word))
        else $error("send word changed between strobes");

    // ready only drops on the cycle after a read command
    a_ready_idle: assert property (@(posedge clk) disable iff (!rstN)
        $fell(ready) |-> $past(cmd.valid && !cmd.rw))
        else $error("ready low with no read pending");

endmodule

bind uart_slave uart_slave_assert i_uart_slave_assert (
    .clk           (clk),
    .rstN          (rstN),
    .send_tx       (send_tx),
    .send_tx_ready (send_tx_ready),
    .get_tx        (get_tx),
    .get_tx_ready  (get_tx_ready),
    .ready         (ready),
    .cmd           (cmd)
);

// ==== tb.f ====
logic/uart_slave_pkg.sv
logic/frame_decode.sv
logic/link_write.sv
logic/read_return.sv
logic/uart_slave.sv
sim/uart_slave_assert.sv
sim/tb_uart_slave.sv
